//--- project.f
+incdir+source
source/vread_pkg.sv
source/buf_port_if.sv
source/burst_reader.sv
source/addr_gen.sv
source/dual_port_buf.sv
source/vread_unit.sv
source/vread_top.sv
testbench/vread_checker.sv
testbench/tb_vread.sv

//--- run_sim.sh
#!/bin/sh
# build and run the vread testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f project.f --top-module tb_vread \
   -o vread_sim || { echo "build failed"; exit 1; }

./obj_dir/vread_sim > sim.log 2>&1
cat sim.log

grep -qx "Test passed" sim.log && echo "simulation ok" || { echo "simulation failed"; exit 1; }

//--- testbench/tb_vread.sv
`timescale 1ns/10ps
`default_nettype none

`include "vread_consts.svh"

module tb_vread;
   import vread_pkg::*;

   localparam int NUM_TESTS    = 7;
   localparam int DONE_TIMEOUT = 4000;

   typedef struct {
      logic       pp;
      logic       rd_en;
      ext_addr_t  ext;
      count_t     count;
      burst_len_t len;
      sym_addr_t  start;
      sym_addr_t  incr;
      sym_addr_t  shift;
      period_t    per;
      period_t    duty;
      count_t     iter;
      int         delay;
      bus_word_t  off;
      logic       gaps;
   } test_row_t;

   test_row_t tests [NUM_TESTS];

   logic                      clk;
   logic                      rst;
   logic                      run_i;
   logic                      pingpong_i;
   logic                      read_enabled_i;
   ext_addr_t                 ext_addr_i;
   count_t                    read_count_i;
   burst_len_t                read_length_i;
   logic                      databus_ready_i;
   bus_word_t                 databus_rdata_i;
   logic                      databus_last_i;
   sym_addr_t                 out_start_i;
   sym_addr_t                 out_incr_i;
   sym_addr_t                 out_shift_i;
   period_t                   out_per_i;
   period_t                   out_duty_i;
   count_t                    out_iter_i;
   logic [`VREAD_DELAY_W-1:0] out_delay_i;
   logic                      databus_valid_o;
   ext_addr_t                 databus_addr_o;
   burst_len_t                databus_len_o;
   symbol_t                   out_o;
   logic                      out_valid_o;
   logic                      done_o;

   integer    seed;
   int        beat_idx;
   int        t;
   logic      took_last;
   logic      timed_out;
   bus_word_t cur_off;
   logic      cur_gaps;

   vread_top dut0 (.*);

   vread_checker chk (
      .clk (clk), .rst (rst), .run_i (run_i),
      .databus_valid_i (databus_valid_o), .databus_addr_i (databus_addr_o),
      .databus_len_i (databus_len_o), .databus_ready_i (databus_ready_i),
      .databus_last_i (databus_last_i), .out_i (out_o),
      .out_valid_i (out_valid_o), .done_i (done_o)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // external memory model where each word holds its byte address plus the test offset
   always @(posedge clk) begin
      took_last = databus_valid_o && databus_ready_i && databus_last_i;
      if (databus_valid_o && databus_ready_i) begin
         beat_idx = databus_last_i ? 0 : beat_idx + 1;
      end
      if (databus_valid_o && !took_last) begin
         databus_ready_i <= cur_gaps ? (($random(seed) & 3) != 0) : 1'b1;
         databus_rdata_i <= databus_addr_o + (ext_addr_t'(beat_idx) << 2) + cur_off;
         databus_last_i  <= (beat_idx == int'(databus_len_o));
      end else begin
         databus_ready_i <= 1'b0;
         databus_last_i  <= 1'b0;
      end
   end

   task automatic set_row(input int i, input logic pp, input logic rd_en, input ext_addr_t ext,
                          input int count, input int len, input int start, input int incr,
                          input int shift, input int per, input int duty, input int iter,
                          input int delay, input bus_word_t off, input logic gaps);
      tests[i] = '{pp, rd_en, ext, count_t'(count), burst_len_t'(len), sym_addr_t'(start),
                   sym_addr_t'(incr), sym_addr_t'(shift), period_t'(per), period_t'(duty),
                   count_t'(iter), delay, off, gaps};
   endtask

   initial begin
      seed = 86101;
      beat_idx = 0;
      cur_off = '0;
      cur_gaps = 1'b0;
      timed_out = 1'b0;
      rst = 1'b1;
      {run_i, pingpong_i, read_enabled_i, ext_addr_i, read_count_i, read_length_i} = '0;
      {databus_ready_i, databus_rdata_i, databus_last_i} = '0;
      {out_start_i, out_incr_i, out_shift_i, out_per_i, out_duty_i, out_iter_i} = '0;
      out_delay_i = '0;

      //           pp rd ext        cnt len st inc sh per dty it dly off  gaps
      set_row(0, 0, 1, 32'h1000, 16, 3, 0, 0, 0, 0, 0, 0, 0, 32'h0, 0);
      set_row(1, 0, 0, 32'h0,    0,  0, 0, 1, 0, 32, 32, 1, 0, 32'h0, 0);
      set_row(2, 0, 1, 32'h2000, 37, 7, 0, 0, 0, 0, 0, 0, 0, 32'h5, 1);
      set_row(3, 0, 0, 32'h0,    0,  0, 3, 2, 9, 5, 3, 4, 6, 32'h0, 0);
      set_row(4, 1, 1, 32'h3000, 20, 4, 0, 0, 0, 0, 0, 0, 0, 32'h11, 0);
      set_row(5, 1, 1, 32'h4000, 20, 4, 0, 1, 0, 40, 40, 1, 2, 32'h22, 1);
      set_row(6, 0, 0, 32'h5000, 8,  3, 512, 1, 4, 4, 4, 2, 0, 32'h0, 0);

      repeat (4) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);
      chk.check_reset();

      for (int i = 0; (i < NUM_TESTS) && !timed_out; i++) begin
         @(posedge clk);
         cur_off  = tests[i].off;
         cur_gaps = tests[i].gaps;
         chk.begin_test(tests[i].pp, tests[i].rd_en, tests[i].ext, tests[i].count,
                        tests[i].len, tests[i].start, tests[i].incr, tests[i].shift,
                        tests[i].per, tests[i].duty, tests[i].iter, tests[i].delay,
                        tests[i].off);
         pingpong_i     <= tests[i].pp;
         read_enabled_i <= tests[i].rd_en;
         ext_addr_i     <= tests[i].ext;
         read_count_i   <= tests[i].count;
         read_length_i  <= tests[i].len;
         out_start_i    <= tests[i].start;
         out_incr_i     <= tests[i].incr;
         out_shift_i    <= tests[i].shift;
         out_per_i      <= tests[i].per;
         out_duty_i     <= tests[i].duty;
         out_iter_i     <= tests[i].iter;
         out_delay_i    <= tests[i].delay[`VREAD_DELAY_W-1:0];
         run_i          <= 1'b1;
         @(posedge clk);
         run_i <= 1'b0;
         // done drops after the run edge and is then polled
         repeat (2) @(posedge clk);
         t = 0;
         while (!done_o && (t < DONE_TIMEOUT)) begin
            @(posedge clk);
            t++;
         end
         if (!done_o) begin
            $display("timeout: done_o did not rise in test %0d", i);
            timed_out = 1'b1;
         end else begin
            // let the final symbol reach the checker
            repeat (3) @(posedge clk);
            chk.end_test(i);
         end
      end

      chk.report();
      if (!timed_out && (chk.err_count == 0)) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- testbench/vread_checker.sv
`timescale 1ns/10ps
`default_nettype none

module vread_checker (
   input wire                        clk,
   input wire                        rst,
   input wire                        run_i,
   input wire                        databus_valid_i,
   input wire vread_pkg::ext_addr_t  databus_addr_i,
   input wire vread_pkg::burst_len_t databus_len_i,
   input wire                        databus_ready_i,
   input wire                        databus_last_i,
   input wire vread_pkg::symbol_t    out_i,
   input wire                        out_valid_i,
   input wire                        done_i
);
   import vread_pkg::*;

   localparam int SW = $bits(sym_addr_t);
   localparam int WW = $bits(word_addr_t);

   // reference copy of the local buffer
   bus_word_t  ref_buf [2**WW];
   symbol_t    exp_q [$];
   int         err_count = 0;
   int         test_count = 0;
   int         test_errs;
   int         cyc = 0;
   int         run_cyc = 0;
   int         exp_first;
   int         sym_count;
   int         beat_count;
   int         exp_beats;
   int         valid_cycles;
   int         remaining;
   int         burst_beats;
   logic       pp_model = 1'b0;
   logic       fill_half;
   logic       read_half;
   logic       rd_en_cur;
   logic       first_beat;
   ext_addr_t  fill_ext;
   ext_addr_t  exp_burst_addr;
   int         fill_count;
   int         len_cur;
   bus_word_t  fill_off;

   task automatic check_reset();
      if (done_i !== 1'b1) begin
         $display("Error at %0t: done_o is %b after reset", $time, done_i);
         err_count++;
      end
      if (databus_valid_i !== 1'b0) begin
         $display("Error at %0t: databus valid is %b after reset", $time, databus_valid_i);
         err_count++;
      end
   endtask

   task automatic begin_test(input logic pp, input logic rd_en, input ext_addr_t ext,
                             input count_t count, input burst_len_t len,
                             input sym_addr_t start, input sym_addr_t incr,
                             input sym_addr_t shift, input period_t per, input period_t duty,
                             input count_t iter, input int delay, input bus_word_t off);
      sym_addr_t  a;
      word_addr_t w;
      bus_word_t  word;
      // halves swap at the run edge and this run sees the new state
      pp_model  = pp ? ~pp_model : 1'b0;
      fill_half = pp & ~pp_model;
      read_half = pp & pp_model;
      exp_q.delete();
      for (int i = 0; i < int'(iter); i++) begin
         for (int j = 0; j < int'(per); j++) begin
            if (j < int'(duty)) begin
               a = start + sym_addr_t'(i) * shift + sym_addr_t'(j) * incr;
               w = {(pp ? read_half : a[SW-1]), a[SW-2:1]};
               word = ref_buf[w];
               exp_q.push_back(a[0] ? word[31:16] : word[15:0]);
            end
         end
      end
      exp_first      = delay + 2;
      sym_count      = 0;
      beat_count     = 0;
      valid_cycles   = 0;
      first_beat     = 1'b1;
      burst_beats    = 0;
      exp_burst_addr = ext;
      remaining      = int'(count);
      len_cur        = int'(len);
      rd_en_cur      = rd_en;
      exp_beats      = rd_en ? int'(count) : 0;
      fill_ext       = ext;
      fill_count     = rd_en ? int'(count) : 0;
      fill_off       = off;
      test_errs      = err_count;
   endtask

   always @(posedge clk) begin
      if (!rst) begin
         cyc++;
         if (run_i) begin
            run_cyc = cyc;
         end
         if (databus_valid_i) begin
            valid_cycles++;
         end
         if (databus_valid_i && databus_ready_i) begin
            if (first_beat) begin
               // a burst carries the configured beats or the words still left
               burst_beats = (remaining < len_cur + 1) ? remaining : len_cur + 1;
               if (databus_addr_i !== exp_burst_addr) begin
                  $display("Error at %0t: burst address %h, expected %h",
                           $time, databus_addr_i, exp_burst_addr);
                  err_count++;
               end
               if (int'(databus_len_i) != burst_beats - 1) begin
                  $display("Error at %0t: burst length %0d with %0d words left",
                           $time, databus_len_i, remaining);
                  err_count++;
               end
            end
            first_beat = 1'b0;
            beat_count++;
            remaining--;
            if (databus_last_i) begin
               exp_burst_addr = exp_burst_addr + ext_addr_t'(4 * burst_beats);
               first_beat = 1'b1;
            end
         end
         if (out_valid_i) begin
            if (exp_q.size() == 0) begin
               $display("Error at %0t: symbol %h arrived when none was expected", $time, out_i);
               err_count++;
            end else begin
               if ((sym_count == 0) && (cyc - run_cyc != exp_first)) begin
                  $display("Error at %0t: first symbol %0d cycles after run, expected %0d",
                           $time, cyc - run_cyc, exp_first);
                  err_count++;
               end
               if (out_i !== exp_q[0]) begin
                  $display("Error at %0t: symbol %0d is %h, expected %h",
                           $time, sym_count, out_i, exp_q[0]);
                  err_count++;
               end
               void'(exp_q.pop_front());
               sym_count++;
            end
         end
      end
   end

   task automatic end_test(input int idx);
      count_t k;
      if (exp_q.size() != 0) begin
         $display("test %0d: %0d expected symbols never arrived", idx, exp_q.size());
         err_count++;
      end
      if (beat_count != exp_beats) begin
         $display("Error at %0t: %0d beats taken, expected %0d", $time, beat_count, exp_beats);
         err_count++;
      end
      if (!rd_en_cur && (valid_cycles != 0)) begin
         $display("test %0d: a burst was issued while reading was disabled", idx);
         err_count++;
      end
      // buffer now holds the words of this run's fill half
      for (k = '0; int'(k) < fill_count; k++) begin
         ref_buf[{k[WW-1] | fill_half, k[WW-2:0]}] = fill_ext + (ext_addr_t'(k) << 2) + fill_off;
      end
      $display("test %0d: %0d symbols, %0d beats, %0d errors",
               idx, sym_count, beat_count, err_count - test_errs);
      test_count++;
   endtask

   task automatic report();
      $display("%0d tests run, %0d errors", test_count, err_count);
   endtask

endmodule

`default_nettype wire

//--- source/vread_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "vread_consts.svh"

module vread_top (
   input  wire                        clk,
   input  wire                        rst,
   input  wire                        run_i,
   input  wire                        pingpong_i,
   input  wire                        read_enabled_i,
   input  wire vread_pkg::ext_addr_t  ext_addr_i,
   input  wire vread_pkg::count_t     read_count_i,
   input  wire vread_pkg::burst_len_t read_length_i,
   input  wire                        databus_ready_i,
   input  wire vread_pkg::bus_word_t  databus_rdata_i,
   input  wire                        databus_last_i,
   input  wire vread_pkg::sym_addr_t  out_start_i,
   input  wire vread_pkg::sym_addr_t  out_incr_i,
   input  wire vread_pkg::sym_addr_t  out_shift_i,
   input  wire vread_pkg::period_t    out_per_i,
   input  wire vread_pkg::period_t    out_duty_i,
   input  wire vread_pkg::count_t     out_iter_i,
   input  wire [`VREAD_DELAY_W-1:0]   out_delay_i,
   output logic                       databus_valid_o,
   output vread_pkg::ext_addr_t       databus_addr_o,
   output vread_pkg::burst_len_t      databus_len_o,
   output vread_pkg::symbol_t         out_o,
   output logic                       out_valid_o,
   output logic                       done_o
);

   // local buffer ports, written by the reader and drained by the generator
   buf_port_if buf_if ();

   vread_unit u_unit (
      .clk             (clk),
      .rst             (rst),
      .run_i           (run_i),
      .pingpong_i      (pingpong_i),
      .read_enabled_i  (read_enabled_i),
      .ext_addr_i      (ext_addr_i),
      .read_count_i    (read_count_i),
      .read_length_i   (read_length_i),
      .databus_ready_i (databus_ready_i),
      .databus_rdata_i (databus_rdata_i),
      .databus_last_i  (databus_last_i),
      .out_start_i     (out_start_i),
      .out_incr_i      (out_incr_i),
      .out_shift_i     (out_shift_i),
      .out_per_i       (out_per_i),
      .out_duty_i      (out_duty_i),
      .out_iter_i      (out_iter_i),
      .out_delay_i     (out_delay_i),
      .databus_valid_o (databus_valid_o),
      .databus_addr_o  (databus_addr_o),
      .databus_len_o   (databus_len_o),
      .out_o           (out_o),
      .out_valid_o     (out_valid_o),
      .done_o          (done_o),
      .buf_wr          (buf_if),
      .buf_rd          (buf_if)
   );

   dual_port_buf u_buf (
      .clk      (clk),
      .mem_port (buf_if)
   );

endmodule

`default_nettype wire

//--- source/vread_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "vread_consts.svh"

module vread_unit (
   input  wire                        clk,
   input  wire                        rst,
   input  wire                        run_i,
   input  wire                        pingpong_i,
   input  wire                        read_enabled_i,
   input  wire vread_pkg::ext_addr_t  ext_addr_i,
   input  wire vread_pkg::count_t     read_count_i,
   input  wire vread_pkg::burst_len_t read_length_i,
   input  wire                        databus_ready_i,
   input  wire vread_pkg::bus_word_t  databus_rdata_i,
   input  wire                        databus_last_i,
   input  wire vread_pkg::sym_addr_t  out_start_i,
   input  wire vread_pkg::sym_addr_t  out_incr_i,
   input  wire vread_pkg::sym_addr_t  out_shift_i,
   input  wire vread_pkg::period_t    out_per_i,
   input  wire vread_pkg::period_t    out_duty_i,
   input  wire vread_pkg::count_t     out_iter_i,
   input  wire [`VREAD_DELAY_W-1:0]   out_delay_i,
   output logic                       databus_valid_o,
   output vread_pkg::ext_addr_t       databus_addr_o,
   output vread_pkg::burst_len_t      databus_len_o,
   output vread_pkg::symbol_t         out_o,
   output logic                       out_valid_o,
   output logic                       done_o,
   buf_port_if.writer                 buf_wr,
   buf_port_if.reader                 buf_rd
);
   import vread_pkg::*;

   localparam int SYM_W = $bits(sym_addr_t);
   localparam int DW    = $bits(symbol_t);

   logic      pp_state;
   logic      fill_half;
   logic      read_half;
   logic      reader_done;
   logic      out_done;
   logic      gen_valid;
   logic      gen_done;
   sym_addr_t gen_addr;
   logic      sel_hi;

   // halves swap on each run while ping-pong is on
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         pp_state <= 1'b0;
      end else if (run_i) begin
         pp_state <= pingpong_i ? ~pp_state : 1'b0;
      end
   end

   assign fill_half = pingpong_i & ~pp_state;
   assign read_half = pingpong_i & pp_state;

   burst_reader u_reader (
      .clk             (clk),
      .rst             (rst),
      .run_i           (run_i & read_enabled_i),
      .start_addr_i    (ext_addr_i),
      .count_i         (read_count_i),
      .length_i        (read_length_i),
      .fill_half_i     (fill_half),
      .databus_ready_i (databus_ready_i),
      .databus_rdata_i (databus_rdata_i),
      .databus_last_i  (databus_last_i),
      .databus_valid_o (databus_valid_o),
      .databus_addr_o  (databus_addr_o),
      .databus_len_o   (databus_len_o),
      .done_o          (reader_done),
      .buf_wr          (buf_wr)
   );

   addr_gen u_gen (
      .clk     (clk),
      .rst     (rst),
      .run_i   (run_i),
      .start_i (out_start_i),
      .incr_i  (out_incr_i),
      .shift_i (out_shift_i),
      .per_i   (out_per_i),
      .duty_i  (out_duty_i),
      .iter_i  (out_iter_i),
      .delay_i (out_delay_i),
      .valid_o (gen_valid),
      .addr_o  (gen_addr),
      .done_o  (gen_done)
   );

   // symbol address to word address, top bit forced to the read half
   assign buf_rd.rd_en   = gen_valid;
   assign buf_rd.rd_addr = {(pingpong_i ? read_half : gen_addr[SYM_W-1]), gen_addr[SYM_W-2:1]};

   // low symbol bit picks the half of the word one cycle later
   always_ff @(posedge clk) begin
      if (gen_valid) begin
         sel_hi <= gen_addr[0];
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         out_valid_o <= 1'b0;
      end else begin
         out_valid_o <= gen_valid;
      end
   end

   assign out_o = sel_hi ? buf_rd.rd_data[2*DW-1:DW] : buf_rd.rd_data[DW-1:0];

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         out_done <= 1'b1;
      end else if (run_i) begin
         out_done <= 1'b0;
      end else if (gen_done) begin
         out_done <= 1'b1;
      end
   end

   assign done_o = out_done & reader_done;

   // with ping-pong the generator must stay inside one half
   a_pp_in_half: assert property (
      @(posedge clk) disable iff (rst) (gen_valid && pingpong_i) |-> !gen_addr[SYM_W-1]
   ) else $error("output address %0d overflows the ping-pong half", gen_addr);

endmodule

`default_nettype wire

//--- source/dual_port_buf.sv
`timescale 1ns/10ps
`default_nettype none

module dual_port_buf (
   input wire      clk,
   buf_port_if.mem mem_port
);
   import vread_pkg::*;

   localparam int DEPTH = 2 ** $bits(word_addr_t);

   bus_word_t ram [DEPTH];

   always_ff @(posedge clk) begin
      if (mem_port.wr_en) begin
         ram[mem_port.wr_addr] <= mem_port.wr_data;
      end
   end

   // registered read, holds the last word while rd_en is low
   always_ff @(posedge clk) begin
      if (mem_port.rd_en) begin
         mem_port.rd_data <= ram[mem_port.rd_addr];
      end
   end

   // fill side and drain side must not meet on one word
   a_no_collision: assert property (
      @(posedge clk)
      !(mem_port.wr_en && mem_port.rd_en && (mem_port.wr_addr == mem_port.rd_addr))
   ) else $error("buffer write and read on word %0d together", mem_port.rd_addr);

endmodule

`default_nettype wire

//--- source/addr_gen.sv
`timescale 1ns/10ps
`default_nettype none

`include "vread_consts.svh"

module addr_gen (
   input  wire                       clk,
   input  wire                       rst,
   input  wire                       run_i,
   input  wire vread_pkg::sym_addr_t start_i,
   input  wire vread_pkg::sym_addr_t incr_i,
   input  wire vread_pkg::sym_addr_t shift_i,
   input  wire vread_pkg::period_t   per_i,
   input  wire vread_pkg::period_t   duty_i,
   input  wire vread_pkg::count_t    iter_i,
   input  wire [`VREAD_DELAY_W-1:0]  delay_i,
   output logic                      valid_o,
   output vread_pkg::sym_addr_t      addr_o,
   output logic                      done_o
);
   import vread_pkg::*;

   gen_state_t                state;
   logic [`VREAD_DELAY_W-1:0] delay_cnt;
   period_t                   step_cnt;
   count_t                    iter_cnt;
   // current step address and step 0 of the current iteration
   sym_addr_t                 addr;
   sym_addr_t                 iter_base;

   logic last_step;
   logic last_iter;

   assign last_step = (step_cnt == per_i - 1'b1);
   assign last_iter = (iter_cnt == iter_i - 1'b1);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state     <= GEN_IDLE;
         delay_cnt <= '0;
         step_cnt  <= '0;
         iter_cnt  <= '0;
         done_o    <= 1'b0;
      end else begin
         done_o <= 1'b0;
         case (state)
            GEN_IDLE: begin
               if (run_i) begin
                  step_cnt  <= '0;
                  iter_cnt  <= '0;
                  delay_cnt <= delay_i - 1'b1;
                  if ((per_i == '0) || (iter_i == '0)) begin
                     // empty loop finishes at once
                     done_o <= 1'b1;
                  end else if (delay_i == '0) begin
                     state <= GEN_RUN;
                  end else begin
                     state <= GEN_DELAY;
                  end
               end
            end
            GEN_DELAY: begin
               delay_cnt <= delay_cnt - 1'b1;
               if (delay_cnt == '0) begin
                  state <= GEN_RUN;
               end
            end
            GEN_RUN: begin
               if (last_step) begin
                  step_cnt <= '0;
                  if (last_iter) begin
                     state  <= GEN_IDLE;
                     done_o <= 1'b1;
                  end else begin
                     iter_cnt <= iter_cnt + 1'b1;
                  end
               end else begin
                  step_cnt <= step_cnt + 1'b1;
               end
            end
            default: begin
               state <= GEN_IDLE;
            end
         endcase
      end
   end

   // incr within a period and shift between periods
   always_ff @(posedge clk) begin
      if ((state == GEN_IDLE) && run_i) begin
         addr      <= start_i;
         iter_base <= start_i;
      end else if (state == GEN_RUN) begin
         if (last_step) begin
            addr      <= iter_base + shift_i;
            iter_base <= iter_base + shift_i;
         end else begin
            addr <= addr + incr_i;
         end
      end
   end

   assign valid_o = (state == GEN_RUN) && (step_cnt < duty_i);
   assign addr_o  = addr;

   // loop config must stay put while the generator steps
   a_steps_in_loop: assert property (
      @(posedge clk) disable iff (rst)
      (state == GEN_RUN) |-> ((step_cnt < per_i) && (iter_cnt < iter_i))
   ) else $error("step %0d or iteration %0d outside the loop", step_cnt, iter_cnt);

endmodule

`default_nettype wire

//--- source/burst_reader.sv
`timescale 1ns/10ps
`default_nettype none

module burst_reader (
   input  wire                        clk,
   input  wire                        rst,
   input  wire                        run_i,
   input  wire vread_pkg::ext_addr_t  start_addr_i,
   input  wire vread_pkg::count_t     count_i,
   input  wire vread_pkg::burst_len_t length_i,
   input  wire                        fill_half_i,
   input  wire                        databus_ready_i,
   input  wire vread_pkg::bus_word_t  databus_rdata_i,
   input  wire                        databus_last_i,
   output logic                       databus_valid_o,
   output vread_pkg::ext_addr_t       databus_addr_o,
   output vread_pkg::burst_len_t      databus_len_o,
   output logic                       done_o,
   buf_port_if.writer                 buf_wr
);
   import vread_pkg::*;

   localparam int WORD_W = $bits(word_addr_t);

   reader_state_t state;
   // words still to fetch over all remaining bursts
   count_t        remaining;
   // beats taken in this run, doubles as the local word offset
   count_t        beat_cnt;
   ext_addr_t     burst_addr;
   burst_len_t    burst_len;

   logic beat;

   // a beat pairs with the next word address, the buffer never stalls
   assign beat = (state == RD_BEATS) && databus_ready_i;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state      <= RD_IDLE;
         remaining  <= '0;
         beat_cnt   <= '0;
         burst_addr <= '0;
         burst_len  <= '0;
         done_o     <= 1'b1;
      end else begin
         case (state)
            RD_IDLE: begin
               if (run_i && (count_i != '0)) begin
                  state      <= RD_REQUEST;
                  remaining  <= count_i;
                  beat_cnt   <= '0;
                  burst_addr <= start_addr_i;
                  done_o     <= 1'b0;
               end
            end
            RD_REQUEST: begin
               // final burst is clipped to the words left
               if (remaining <= count_t'(length_i) + 1'b1) begin
                  burst_len <= burst_len_t'(remaining - 1'b1);
               end else begin
                  burst_len <= length_i;
               end
               state <= RD_BEATS;
            end
            RD_BEATS: begin
               if (beat) begin
                  remaining <= remaining - 1'b1;
                  beat_cnt  <= beat_cnt + 1'b1;
                  if (databus_last_i) begin
                     // next burst starts 4 bytes per beat further
                     burst_addr <= burst_addr + ((ext_addr_t'(burst_len) + 1'b1) << 2);
                     if (remaining == count_t'(1)) begin
                        state  <= RD_IDLE;
                        done_o <= 1'b1;
                     end else begin
                        state <= RD_REQUEST;
                     end
                  end
               end
            end
            default: begin
               state <= RD_IDLE;
            end
         endcase
      end
   end

   // request held steady for the whole burst
   assign databus_valid_o = (state == RD_BEATS);
   assign databus_addr_o  = burst_addr;
   assign databus_len_o   = burst_len;

   // top word bit selects the fill half when ping-pong is on
   assign buf_wr.wr_en   = beat;
   assign buf_wr.wr_addr = {beat_cnt[WORD_W-1] | fill_half_i, beat_cnt[WORD_W-2:0]};
   assign buf_wr.wr_data = databus_rdata_i;

   // memory must end the last burst on the clipped length
   a_beats_in_count: assert property (
      @(posedge clk) disable iff (rst) beat |-> (beat_cnt < count_i)
   ) else $error("more beats than the %0d words requested", count_i);

endmodule

`default_nettype wire

//--- source/buf_port_if.sv
`timescale 1ns/10ps
`default_nettype none

interface buf_port_if;
   import vread_pkg::*;

   // write port, one bus word per beat
   logic       wr_en;
   word_addr_t wr_addr;
   bus_word_t  wr_data;

   // read port, data valid the cycle after rd_en
   logic       rd_en;
   word_addr_t rd_addr;
   bus_word_t  rd_data;

   modport writer (
      output wr_en,
      output wr_addr,
      output wr_data
   );

   modport reader (
      output rd_en,
      output rd_addr,
      input  rd_data
   );

   modport mem (
      input  wr_en,
      input  wr_addr,
      input  wr_data,
      input  rd_en,
      input  rd_addr,
      output rd_data
   );

endinterface

`default_nettype wire

//--- source/vread_pkg.sv
`default_nettype none

`include "vread_consts.svh"

package vread_pkg;

   // data
   typedef logic [`VREAD_AXI_DATA_W-1:0] bus_word_t;
   typedef logic [`VREAD_DATA_W-1:0]     symbol_t;

   // local addresses, a buffer word holds two symbols
   typedef logic [`VREAD_ADDR_W-1:0]     sym_addr_t;
   typedef logic [`VREAD_ADDR_W-2:0]     word_addr_t;

   // external byte address
   typedef logic [`VREAD_EXT_ADDR_W-1:0] ext_addr_t;

   // config fields
   typedef logic [`VREAD_LEN_W-1:0]      burst_len_t;
   typedef logic [`VREAD_PERIOD_W-1:0]   period_t;
   typedef logic [`VREAD_ADDR_W-1:0]     count_t;

   typedef enum logic [1:0] {
      RD_IDLE,
      RD_REQUEST,
      RD_BEATS
   } reader_state_t;

   typedef enum logic [1:0] {
      GEN_IDLE,
      GEN_DELAY,
      GEN_RUN
   } gen_state_t;

endpackage

`default_nettype wire

//--- source/vread_consts.svh
`ifndef VREAD_CONSTS_SVH
`define VREAD_CONSTS_SVH

// databus side
`define VREAD_AXI_DATA_W 32
`define VREAD_EXT_ADDR_W 32
`define VREAD_LEN_W 8

// output symbols, two per bus word
`define VREAD_DATA_W 16

// symbol address into the local buffer
// one bit wider than the buffer word address
`define VREAD_ADDR_W 10

// output generator config
`define VREAD_PERIOD_W 8
`define VREAD_DELAY_W 8

`endif
